// File: Makefile
# Verilator build and run for the register rename block

VERILATOR  ?= verilator
TOP        ?= rename_unit_tb
FILELIST   ?= project.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing --assert -j 0
LINT_FLAGS ?= --lint-only --timing
PASS_MSG   ?= Simulation finished: PASS

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "Run passed, log in $(LOG)"; \
	else \
		echo "Run failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: bench/rename_patterns.txt
// lane0 ctl rs1 rs2 rd, lane1 same (ctl bits valid rs1v rs2v rdv), commit0/1 valid arch phys stale
// flush, ready now, then next-cycle result per lane: valid prd prs1 prs2 stale_prd
0 00 00 00  0 00 00 00  0 00 00 00  0 00 00 00  0 1  0 00 00 00 00  0 00 00 00 00
E 03 05 00  C 00 07 00  0 00 00 00  0 00 00 00  0 1  1 00 03 05 00  1 00 00 00 00
F 01 02 05  F 03 04 06  0 00 00 00  0 00 00 00  0 1  1 20 01 02 05  1 21 03 04 06
F 05 00 00  F 06 01 07  0 00 00 00  0 00 00 00  0 1  1 00 20 00 00  1 22 21 01 07
F 07 07 08  F 08 05 08  0 00 00 00  0 00 00 00  0 1  1 23 22 22 08  1 24 23 20 23
E 08 06 00  7 00 00 09  0 00 00 00  0 00 00 00  0 1  1 00 24 21 00  0 00 00 00 00
9 05 06 09  9 00 00 0A  0 00 00 00  0 00 00 00  0 1  1 25 00 00 09  1 26 00 00 0A
9 00 00 0B  9 00 00 0C  0 00 00 00  0 00 00 00  0 1  1 27 00 00 0B  1 28 00 00 0C
9 00 00 0D  9 00 00 0E  0 00 00 00  0 00 00 00  0 1  1 29 00 00 0D  1 2A 00 00 0E
9 00 00 0F  9 00 00 10  0 00 00 00  0 00 00 00  0 1  1 2B 00 00 0F  1 2C 00 00 10
9 00 00 11  9 00 00 12  0 00 00 00  0 00 00 00  0 1  1 2D 00 00 11  1 2E 00 00 12
9 00 00 13  9 00 00 14  0 00 00 00  0 00 00 00  0 0  0 00 00 00 00  0 00 00 00 00
9 00 00 13  E 09 12 00  0 00 00 00  0 00 00 00  0 1  1 2F 00 00 13  1 00 25 2E 00
9 00 00 14  E 01 02 00  0 00 00 00  0 00 00 00  0 0  0 00 00 00 00  0 00 00 00 00
E 13 12 00  E 05 08 00  0 00 00 00  0 00 00 00  0 1  1 00 2F 2E 00  1 00 20 24 00
9 00 00 14  9 00 00 15  1 05 20 05  1 06 21 06  0 0  0 00 00 00 00  0 00 00 00 00
9 00 00 14  9 00 00 15  1 07 22 07  1 08 23 08  0 1  1 05 00 00 14  1 06 00 00 15
9 00 00 16  F 16 14 17  1 08 24 23  1 00 00 2A  0 1  1 07 00 00 16  1 08 07 05 17
9 00 00 18  0 00 00 00  1 09 25 09  0 00 00 00  1 0  0 00 00 00 00  0 00 00 00 00
F 14 09 0A  F 0A 08 0B  0 00 00 00  0 00 00 00  0 1  1 26 14 25 0A  1 27 26 24 0B
0 00 00 00  0 00 00 00  0 00 00 00  0 00 00 00  0 1  0 00 00 00 00  0 00 00 00 00

// File: bench/rename_unit_tb.sv
`timescale 1ns/1ps

module rename_unit_tb
    import isa_pkg::*, rename_pkg::*;
();

    // ==============================================
    // Pattern file layout
    // ==============================================
    localparam string PATTERN_FILE = "bench/rename_patterns.txt";
    localparam int NUM_LINES      = 21;
    localparam int WORDS_PER_LINE = 28;
    localparam int NUM_WORDS      = NUM_LINES * WORDS_PER_LINE;
    localparam int WORD_IDX_W     = $clog2(NUM_WORDS);

    // Word offsets within one line
    localparam int LANE_WORDS     = 4;
    localparam int COMMIT_BASE    = 8;
    localparam int FLUSH_IDX      = 16;
    localparam int READY_IDX      = 17;
    localparam int EXP_BASE       = 18;
    localparam int EXP_LANE_WORDS = 5;

    localparam int RESET_CYCLES   = 4;
    localparam int TIMEOUT_CYCLES = NUM_LINES + 20;

    logic                       clk;
    logic                       reset;
    logic                       flush;
    decoded_uop_t [FETCH_W-1:0] dec_bundle;
    logic                       rename_ready;
    renamed_uop_t [FETCH_W-1:0] ren_bundle;
    commit_t [FETCH_W-1:0]      commit;

    logic [7:0] pat_mem   [NUM_WORDS];
    logic [7:0] cur_words [WORDS_PER_LINE];
    // Expected outputs of the bundle now sitting in the output register
    logic [7:0] exp_words [WORDS_PER_LINE];

    int load_errors   = 0;
    int ready_errors  = 0;
    int bundle_errors = 0;
    int total_errors  = 0;
    int cycle_count   = 0;

    rename_unit DUT (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .dec_bundle   (dec_bundle),
        .rename_ready (rename_ready),
        .ren_bundle   (ren_bundle),
        .commit       (commit)
    );

    always #10 clk = ~clk;

    // Run length guard
    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    // ==============================================
    // Helpers
    // ==============================================
    function automatic int value_mismatch(input string name, input string where,
                                          input logic [31:0] got, input logic [31:0] exp);
        int bad;
        bad = 0;
        assert (got === exp) else begin
            $display("Error: %s = 0x%0h, expected 0x%0h (%s)", name, got, exp, where);
            bad = 1;
        end
        return bad;
    endfunction

    task automatic fetch_line(input int line);
        logic [WORD_IDX_W-1:0] idx;
        for (int k = 0; k < WORDS_PER_LINE; k++) begin
            idx          = WORD_IDX_W'(line * WORDS_PER_LINE + k);
            cur_words[k] = pat_mem[idx];
        end
    endtask

    // Called right after a rising edge
    task automatic drive_line();
        decoded_uop_t [FETCH_W-1:0] uops;
        commit_t [FETCH_W-1:0]      recs;
        int                         b;
        for (int i = 0; i < FETCH_W; i++) begin
            b                 = i * LANE_WORDS;
            uops[i]           = '0;
            // Control nibble is valid, rs1_valid, rs2_valid, rd_valid
            uops[i].valid     = cur_words[b][3];
            uops[i].rs1_valid = cur_words[b][2];
            uops[i].rs2_valid = cur_words[b][1];
            uops[i].rd_valid  = cur_words[b][0];
            uops[i].rs1       = cur_words[b + 1][ARCH_W-1:0];
            uops[i].rs2       = cur_words[b + 2][ARCH_W-1:0];
            uops[i].rd        = cur_words[b + 3][ARCH_W-1:0];

            b                 = COMMIT_BASE + i * LANE_WORDS;
            recs[i].valid     = cur_words[b][0];
            recs[i].arch_rd   = cur_words[b + 1][ARCH_W-1:0];
            recs[i].phys_rd   = cur_words[b + 2][PHYS_W-1:0];
            recs[i].stale_prd = cur_words[b + 3][PHYS_W-1:0];
        end
        dec_bundle <= uops;
        commit     <= recs;
        flush      <= cur_words[FLUSH_IDX][0];
    endtask

    task automatic drive_idle();
        dec_bundle <= '0;
        commit     <= '0;
        flush      <= 1'b0;
    endtask

    task automatic check_ready(input int line);
        ready_errors += value_mismatch("rename_ready", $sformatf("pattern line %0d", line),
                                       32'(rename_ready), 32'(cur_words[READY_IDX]));
    endtask

    // Payload fields only matter for a valid lane
    task automatic check_bundle(input int line);
        string where;
        int    b;
        int    d;
        where = $sformatf("result of pattern line %0d", line);
        for (int i = 0; i < FETCH_W; i++) begin
            b = EXP_BASE + i * EXP_LANE_WORDS;
            d = i * LANE_WORDS;
            bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].valid", i), where,
                                            32'(ren_bundle[i].valid), 32'(exp_words[b]));
            if (exp_words[b][0]) begin
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].prd", i), where,
                                                32'(ren_bundle[i].prd), 32'(exp_words[b + 1]));
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].prs1", i), where,
                                                32'(ren_bundle[i].prs1), 32'(exp_words[b + 2]));
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].prs2", i), where,
                                                32'(ren_bundle[i].prs2), 32'(exp_words[b + 3]));
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].stale_prd", i),
                                                where, 32'(ren_bundle[i].stale_prd),
                                                32'(exp_words[b + 4]));
                // A lane owns a destination exactly when it was given a tag
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].rd_valid", i),
                                                where, 32'(ren_bundle[i].rd_valid),
                                                32'(exp_words[b + 1] != 8'h00));
                // Architectural fields travel with the uop as driven
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].rs1_valid", i),
                                                where, 32'(ren_bundle[i].rs1_valid),
                                                32'(exp_words[d][2]));
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].rs2_valid", i),
                                                where, 32'(ren_bundle[i].rs2_valid),
                                                32'(exp_words[d][1]));
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].rs1", i), where,
                                                32'(ren_bundle[i].rs1), 32'(exp_words[d + 1]));
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].rs2", i), where,
                                                32'(ren_bundle[i].rs2), 32'(exp_words[d + 2]));
                bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].rd", i), where,
                                                32'(ren_bundle[i].rd), 32'(exp_words[d + 3]));
            end
        end
    endtask

    task automatic check_reset_state();
        for (int i = 0; i < FETCH_W; i++) begin
            bundle_errors += value_mismatch($sformatf("ren_bundle[%0d].valid", i),
                                            "after reset", 32'(ren_bundle[i].valid), 32'd0);
        end
        ready_errors += value_mismatch("rename_ready", "after reset",
                                       32'(rename_ready), 32'd1);
    endtask

    // ==============================================
    // Main sequence
    // ==============================================
    initial begin
        clk        = 1'b0;
        reset      = 1'b1;
        flush      = 1'b0;
        dec_bundle = '0;
        commit     = '0;

        $readmemh(PATTERN_FILE, pat_mem);
        assert (!$isunknown(pat_mem[NUM_WORDS-1])) else begin
            $display("Pattern file %s is missing or holds fewer than %0d lines",
                     PATTERN_FILE, NUM_LINES);
            load_errors++;
        end

        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        @(negedge clk);
        check_reset_state();

        if (load_errors == 0) begin
            for (int line = 0; line < NUM_LINES; line++) begin
                @(posedge clk);
                fetch_line(line);
                drive_line();
                @(negedge clk);
                check_ready(line);
                if (line > 0) begin
                    check_bundle(line - 1);
                end
                exp_words = cur_words;
            end
            // One more cycle to see the last bundle
            @(posedge clk);
            drive_idle();
            @(negedge clk);
            check_bundle(NUM_LINES - 1);
        end

        total_errors = load_errors + ready_errors + bundle_errors;
        $display("Error counts: load %0d, rename_ready %0d, ren_bundle %0d, total %0d",
                 load_errors, ready_errors, bundle_errors, total_errors);
        if (total_errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// File: design/free_list.sv
`timescale 1ns/1ps

module free_list
    import isa_pkg::*, rename_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,
    input  logic [FETCH_W-1:0]          alloc_en,
    output phys_reg_t [FETCH_W-1:0]     alloc_tag,
    output logic [FREE_PTR_W-1:0]       free_count,
    input  commit_t [FETCH_W-1:0]       commit
);

    // Circular buffer of free tags
    phys_reg_t fifo [FREE_REGS];

    // Pointers carry a wrap bit above the index
    logic [FREE_PTR_W-1:0] spec_head;
    logic [FREE_PTR_W-1:0] commit_head;
    logic [FREE_PTR_W-1:0] tail;

    logic [FREE_PTR_W-1:0] pop_cnt;
    logic [FREE_PTR_W-1:0] push_cnt;
    logic [FETCH_W-1:0]    push_en;
    logic [FREE_PTR_W-1:0] push_ptr [FETCH_W];

    // ==============================================
    // Pop and push bookkeeping
    // ==============================================
    always_comb begin
        pop_cnt  = '0;
        push_cnt = '0;
        for (int i = 0; i < FETCH_W; i++) begin
            pop_cnt = pop_cnt + FREE_PTR_W'(alloc_en[i]);
            // Only real destinations return a stale tag
            push_en[i]  = commit[i].valid && (commit[i].arch_rd != '0);
            push_ptr[i] = tail + push_cnt;
            push_cnt    = push_cnt + FREE_PTR_W'(push_en[i]);
        end
    end

    // Next tags in FIFO order, lane 0 first
    always_comb begin
        logic [FREE_PTR_W-1:0] rd_ptr;
        for (int i = 0; i < FETCH_W; i++) begin
            rd_ptr       = spec_head + FREE_PTR_W'(i);
            alloc_tag[i] = fifo[rd_ptr[FREE_PTR_W-2:0]];
        end
    end

    assign free_count = tail - spec_head;

    // ==============================================
    // Pointer and storage update
    // ==============================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            spec_head   <= '0;
            commit_head <= '0;
            // Full at reset, wrap bit set
            tail        <= FREE_PTR_W'(FREE_REGS);
            for (int i = 0; i < FREE_REGS; i++) begin
                fifo[i] <= PHYS_W'(ARCH_REGS + i);
            end
        end else begin
            for (int i = 0; i < FETCH_W; i++) begin
                if (push_en[i]) begin
                    fifo[push_ptr[i][FREE_PTR_W-2:0]] <= commit[i].stale_prd;
                end
            end
            tail        <= tail + push_cnt;
            commit_head <= commit_head + push_cnt;

            // Flush rewinds to the committed head, this cycle's commits included
            if (flush) begin
                spec_head <= commit_head + push_cnt;
            end else begin
                spec_head <= spec_head + pop_cnt;
            end
        end
    end

endmodule

// File: design/isa_pkg.sv
package isa_pkg;

    // ==============================================
    // Core front-end sizes
    // ==============================================
    localparam int FETCH_W   = 2;
    localparam int ARCH_REGS = 32;
    localparam int ARCH_W    = $clog2(ARCH_REGS);
    localparam int OPCODE_W  = 6;
    localparam int FUNC_W    = 6;
    localparam int XLEN      = 32;

    // Architectural register index, x0 is hardwired zero
    typedef logic [ARCH_W-1:0] arch_reg_t;

    // ==============================================
    // Decoded micro-op as delivered by the decoder
    // ==============================================
    typedef struct packed {
        logic                valid;
        logic [OPCODE_W-1:0] opcode;
        arch_reg_t           rs1;
        arch_reg_t           rs2;
        arch_reg_t           rd;
        logic                rs1_valid;
        logic                rs2_valid;
        logic                rd_valid;
        // Functional unit class
        logic                is_alu;
        logic                is_load;
        logic                is_store;
        logic                is_branch;
        logic                is_cas;
        logic [FUNC_W-1:0]   alu_func;
        logic [XLEN-1:0]     imm;
        logic [XLEN-1:0]     pc;
    } decoded_uop_t;

endpackage

// File: design/rename_pkg.sv
package rename_pkg;

    import isa_pkg::*;

    // ==============================================
    // Physical register file sizing
    // ==============================================
    localparam int PHYS_REGS  = 48;
    localparam int PHYS_W     = $clog2(PHYS_REGS);
    // Tags not held by the initial identity map
    localparam int FREE_REGS  = PHYS_REGS - ARCH_REGS;
    // Index bits plus one wrap bit
    localparam int FREE_PTR_W = $clog2(FREE_REGS) + 1;

    typedef logic [PHYS_W-1:0] phys_reg_t;

    // ==============================================
    // Renamed micro-op toward dispatch
    // ==============================================
    typedef struct packed {
        logic                valid;
        logic [OPCODE_W-1:0] opcode;
        arch_reg_t           rs1;
        arch_reg_t           rs2;
        arch_reg_t           rd;
        logic                rs1_valid;
        logic                rs2_valid;
        logic                rd_valid;
        logic                is_alu;
        logic                is_load;
        logic                is_store;
        logic                is_branch;
        logic                is_cas;
        logic [FUNC_W-1:0]   alu_func;
        logic [XLEN-1:0]     imm;
        logic [XLEN-1:0]     pc;
        // Physical tags
        phys_reg_t           prs1;
        phys_reg_t           prs2;
        phys_reg_t           prd;
        phys_reg_t           stale_prd;  // freed when this uop retires
    } renamed_uop_t;

    // Retire record, one per commit lane
    typedef struct packed {
        logic      valid;
        arch_reg_t arch_rd;
        phys_reg_t phys_rd;
        phys_reg_t stale_prd;
    } commit_t;

endpackage

// File: design/rename_stage.sv
`timescale 1ns/1ps

module rename_stage
    import isa_pkg::*, rename_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,

    // Decoder side
    input  decoded_uop_t [FETCH_W-1:0]    dec_bundle,
    output logic                          rename_ready,

    // Dispatch side
    output renamed_uop_t [FETCH_W-1:0]    ren_bundle,

    // Map lookups
    output arch_reg_t [FETCH_W-1:0]       src_rs1,
    output arch_reg_t [FETCH_W-1:0]       src_rs2,
    output arch_reg_t [FETCH_W-1:0]       lookup_rd,
    input  phys_reg_t [FETCH_W-1:0]       map_rs1,
    input  phys_reg_t [FETCH_W-1:0]       map_rs2,
    input  phys_reg_t [FETCH_W-1:0]       map_rd,

    // Map updates
    output logic [FETCH_W-1:0]            write_en,
    output arch_reg_t [FETCH_W-1:0]       write_arch,
    output phys_reg_t [FETCH_W-1:0]       write_tag,

    // Free list
    output logic [FETCH_W-1:0]            alloc_en,
    input  phys_reg_t [FETCH_W-1:0]       alloc_tag,
    input  logic [FREE_PTR_W-1:0]         free_count
);

    logic [FETCH_W-1:0]         need;
    logic [FREE_PTR_W-1:0]      need_cnt;
    phys_reg_t [FETCH_W-1:0]    new_tag;
    renamed_uop_t [FETCH_W-1:0] ren_next;

    logic [FETCH_W-1:0]         out_valid;
    renamed_uop_t [FETCH_W-1:0] out_uop;

    // ==============================================
    // Destination demand and tag assignment
    // ==============================================
    always_comb begin
        int unsigned slot;
        slot     = 0;
        need_cnt = '0;
        for (int i = 0; i < FETCH_W; i++) begin
            need[i] = dec_bundle[i].valid && dec_bundle[i].rd_valid &&
                      (dec_bundle[i].rd != '0);
            // Lanes take free tags in order, skipping lanes without a destination
            new_tag[i] = alloc_tag[slot];
            slot       = slot + 32'(need[i]);
            need_cnt   = need_cnt + FREE_PTR_W'(need[i]);
        end
    end

    // Whole bundle or nothing
    assign rename_ready = (free_count >= need_cnt) && !flush;
    assign alloc_en     = need & {FETCH_W{rename_ready}};
    assign write_en     = alloc_en;
    assign write_tag    = new_tag;

    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            src_rs1[i]    = dec_bundle[i].rs1;
            src_rs2[i]    = dec_bundle[i].rs2;
            lookup_rd[i]  = dec_bundle[i].rd;
            write_arch[i] = dec_bundle[i].rd;
        end
    end

    // ==============================================
    // Per-lane rename with intra-bundle bypass
    // ==============================================
    always_comb begin
        phys_reg_t prs1;
        phys_reg_t prs2;
        phys_reg_t stale;
        for (int i = 0; i < FETCH_W; i++) begin
            // x0 and unused sources read tag 0
            prs1  = (dec_bundle[i].rs1_valid && dec_bundle[i].rs1 != '0) ? map_rs1[i] : '0;
            prs2  = (dec_bundle[i].rs2_valid && dec_bundle[i].rs2 != '0) ? map_rs2[i] : '0;
            stale = map_rd[i];

            // Older lanes in the bundle override the table, the youngest one last
            for (int j = 0; j < i; j++) begin
                if (need[j] && dec_bundle[i].rs1_valid && dec_bundle[j].rd == dec_bundle[i].rs1) begin
                    prs1 = new_tag[j];
                end
                if (need[j] && dec_bundle[i].rs2_valid && dec_bundle[j].rd == dec_bundle[i].rs2) begin
                    prs2 = new_tag[j];
                end
                if (need[j] && dec_bundle[j].rd == dec_bundle[i].rd) begin
                    stale = new_tag[j];
                end
            end

            ren_next[i].valid     = dec_bundle[i].valid;
            ren_next[i].opcode    = dec_bundle[i].opcode;
            ren_next[i].rs1       = dec_bundle[i].rs1;
            ren_next[i].rs2       = dec_bundle[i].rs2;
            ren_next[i].rd        = dec_bundle[i].rd;
            ren_next[i].rs1_valid = dec_bundle[i].rs1_valid;
            ren_next[i].rs2_valid = dec_bundle[i].rs2_valid;
            ren_next[i].rd_valid  = need[i];
            ren_next[i].is_alu    = dec_bundle[i].is_alu;
            ren_next[i].is_load   = dec_bundle[i].is_load;
            ren_next[i].is_store  = dec_bundle[i].is_store;
            ren_next[i].is_branch = dec_bundle[i].is_branch;
            ren_next[i].is_cas    = dec_bundle[i].is_cas;
            ren_next[i].alu_func  = dec_bundle[i].alu_func;
            ren_next[i].imm       = dec_bundle[i].imm;
            ren_next[i].pc        = dec_bundle[i].pc;
            ren_next[i].prs1      = prs1;
            ren_next[i].prs2      = prs2;
            ren_next[i].prd       = need[i] ? new_tag[i] : '0;
            ren_next[i].stale_prd = need[i] ? stale : '0;
        end
    end

    // ==============================================
    // Output register toward dispatch
    // ==============================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            out_valid <= '0;
        end else if (flush || !rename_ready) begin
            out_valid <= '0;
        end else begin
            for (int i = 0; i < FETCH_W; i++) begin
                out_valid[i] <= dec_bundle[i].valid;
            end
        end
    end

    // Payload only, valids live above
    always_ff @(posedge clk) begin
        if (rename_ready) begin
            out_uop <= ren_next;
        end
    end

    always_comb begin
        ren_bundle = out_uop;
        for (int i = 0; i < FETCH_W; i++) begin
            ren_bundle[i].valid = out_valid[i];
        end
    end

endmodule

// File: design/rename_table.sv
`timescale 1ns/1ps

module rename_table
    import isa_pkg::*, rename_pkg::*;
(
    input  logic                        clk,
    input  logic                        reset,
    input  logic                        flush,

    // Source and destination lookups
    input  arch_reg_t [FETCH_W-1:0]     src_rs1,
    input  arch_reg_t [FETCH_W-1:0]     src_rs2,
    output phys_reg_t [FETCH_W-1:0]     map_rs1,
    output phys_reg_t [FETCH_W-1:0]     map_rs2,
    output phys_reg_t [FETCH_W-1:0]     map_rd,
    input  arch_reg_t [FETCH_W-1:0]     lookup_rd,

    // Speculative updates from rename
    input  logic [FETCH_W-1:0]          write_en,
    input  arch_reg_t [FETCH_W-1:0]     write_arch,
    input  phys_reg_t [FETCH_W-1:0]     write_tag,

    // Retire
    input  commit_t [FETCH_W-1:0]       commit
);

    phys_reg_t spec_map    [ARCH_REGS];
    phys_reg_t commit_map  [ARCH_REGS];
    phys_reg_t commit_next [ARCH_REGS];

    // ==============================================
    // Committed map with this cycle's retirements
    // ==============================================
    always_comb begin
        commit_next = commit_map;
        // Lane order, so a younger retire wins
        for (int i = 0; i < FETCH_W; i++) begin
            if (commit[i].valid && (commit[i].arch_rd != '0)) begin
                commit_next[commit[i].arch_rd] = commit[i].phys_rd;
            end
        end
    end

    // ==============================================
    // Combinational lookups
    // ==============================================
    always_comb begin
        for (int i = 0; i < FETCH_W; i++) begin
            map_rs1[i] = spec_map[src_rs1[i]];
            map_rs2[i] = spec_map[src_rs2[i]];
            map_rd[i]  = spec_map[lookup_rd[i]];
        end
    end

    // ==============================================
    // Map state
    // ==============================================
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            // Identity mapping, arch i holds tag i
            for (int r = 0; r < ARCH_REGS; r++) begin
                spec_map[r]   <= PHYS_W'(r);
                commit_map[r] <= PHYS_W'(r);
            end
        end else begin
            commit_map <= commit_next;

            if (flush) begin
                // Recover speculative state from retired state
                spec_map <= commit_next;
            end else begin
                // Later lane overrides an earlier write to the same register
                for (int i = 0; i < FETCH_W; i++) begin
                    if (write_en[i]) begin
                        spec_map[write_arch[i]] <= write_tag[i];
                    end
                end
            end
        end
    end

endmodule

// File: design/rename_unit.sv
`timescale 1ns/1ps

module rename_unit
    import isa_pkg::*, rename_pkg::*;
(
    input  logic                          clk,
    input  logic                          reset,
    input  logic                          flush,
    input  decoded_uop_t [FETCH_W-1:0]    dec_bundle,
    output logic                          rename_ready,
    output renamed_uop_t [FETCH_W-1:0]    ren_bundle,
    input  commit_t [FETCH_W-1:0]         commit
);

    // Stage to table
    arch_reg_t [FETCH_W-1:0] src_rs1;
    arch_reg_t [FETCH_W-1:0] src_rs2;
    arch_reg_t [FETCH_W-1:0] lookup_rd;
    phys_reg_t [FETCH_W-1:0] map_rs1;
    phys_reg_t [FETCH_W-1:0] map_rs2;
    phys_reg_t [FETCH_W-1:0] map_rd;
    logic [FETCH_W-1:0]      write_en;
    arch_reg_t [FETCH_W-1:0] write_arch;
    phys_reg_t [FETCH_W-1:0] write_tag;

    // Stage to free list
    logic [FETCH_W-1:0]      alloc_en;
    phys_reg_t [FETCH_W-1:0] alloc_tag;
    logic [FREE_PTR_W-1:0]   free_count;

    // ==============================================
    // Submodules
    // ==============================================
    free_list u_free_list (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .alloc_en   (alloc_en),
        .alloc_tag  (alloc_tag),
        .free_count (free_count),
        .commit     (commit)
    );

    rename_table u_rename_table (
        .clk        (clk),
        .reset      (reset),
        .flush      (flush),
        .src_rs1    (src_rs1),
        .src_rs2    (src_rs2),
        .map_rs1    (map_rs1),
        .map_rs2    (map_rs2),
        .map_rd     (map_rd),
        .lookup_rd  (lookup_rd),
        .write_en   (write_en),
        .write_arch (write_arch),
        .write_tag  (write_tag),
        .commit     (commit)
    );

    rename_stage u_rename_stage (
        .clk          (clk),
        .reset        (reset),
        .flush        (flush),
        .dec_bundle   (dec_bundle),
        .rename_ready (rename_ready),
        .ren_bundle   (ren_bundle),
        .src_rs1      (src_rs1),
        .src_rs2      (src_rs2),
        .lookup_rd    (lookup_rd),
        .map_rs1      (map_rs1),
        .map_rs2      (map_rs2),
        .map_rd       (map_rd),
        .write_en     (write_en),
        .write_arch   (write_arch),
        .write_tag    (write_tag),
        .alloc_en     (alloc_en),
        .alloc_tag    (alloc_tag),
        .free_count   (free_count)
    );

endmodule

// File: project.f
design/isa_pkg.sv
design/rename_pkg.sv
design/free_list.sv
design/rename_table.sv
design/rename_stage.sv
design/rename_unit.sv
bench/rename_unit_tb.sv
